//--- verilog/layer_pkg.sv
package layer_pkg;

    ////////////////////
    // Widths
    ////////////////////
    localparam int bus_addr_width    = 18;  // Byte address on the bus
    localparam int word_addr_width   = 16;
    localparam int bus_data_width    = 32;
    localparam int linebuf_idx_width = 10;
    localparam int reg_addr_width    = 4;
    localparam int reg_data_width    = 8;

    // Pixels in one display line
    localparam logic [linebuf_idx_width-1:0] line_pixels = 10'd640;

    ////////////////////
    // Register map
    ////////////////////
    localparam logic [reg_addr_width-1:0] reg_ctrl0      = 4'h0;
    localparam logic [reg_addr_width-1:0] reg_base_lo    = 4'h4;
    localparam logic [reg_addr_width-1:0] reg_base_hi    = 4'h5;
    localparam logic [reg_addr_width-1:0] reg_stride     = 4'h6;
    localparam logic [reg_addr_width-1:0] reg_hscroll_hi = 4'h7;  // Palette offset lives here

    localparam logic [word_addr_width-1:0] base_reset = 16'h8000;  // In words

    // Only the bitmap modes render
    localparam logic [2:0] mode_bmp2 = 3'd5;
    localparam logic [2:0] mode_bmp4 = 3'd6;
    localparam logic [2:0] mode_bmp8 = 3'd7;

    ////////////////////
    // Fetch FSM
    ////////////////////
    localparam int fetch_state_width = 2;
    localparam logic [fetch_state_width-1:0] fetch_idle  = 2'd0;
    localparam logic [fetch_state_width-1:0] fetch_issue = 2'd1;
    localparam logic [fetch_state_width-1:0] fetch_wait  = 2'd2;  // Strobe out and waiting for ack
    localparam logic [fetch_state_width-1:0] fetch_hold  = 2'd3;  // Word offered downstream

    // One bus word seen at each colour depth with byte 0 in bits 7:0
    typedef union packed {
        logic [bus_data_width/8-1:0][7:0] bytes;
        logic [bus_data_width/4-1:0][3:0] nibbles;
        logic [bus_data_width/2-1:0][1:0] pairs;
    } fetch_word_t;

endpackage

//--- verilog/layer_regs.sv
`timescale 1ns/1ps

module layer_regs (
    input  logic                                  clk,
    input  logic                                  rst,

    // Register bus
    input  logic [layer_pkg::reg_addr_width-1:0]  regs_addr,
    input  logic [layer_pkg::reg_data_width-1:0]  regs_wrdata,
    input  logic                                  regs_write,
    output logic [layer_pkg::reg_data_width-1:0]  regs_rddata,

    // Layer controls
    output logic [2:0]                            mode,
    output logic [1:0]                            vscale,
    output logic [1:0]                            hscale,
    output logic                                  enable,
    output logic [layer_pkg::word_addr_width-1:0] bitmap_base,
    output logic [7:0]                            stride,
    output logic [3:0]                            palette_offset
);
    import layer_pkg::*;

    ////////////////////
    // Write decode
    ////////////////////
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            mode           <= 3'd0;
            vscale         <= 2'd0;
            hscale         <= 2'd0;
            enable         <= 1'b0;
            bitmap_base    <= base_reset;
            stride         <= 8'd0;
            palette_offset <= 4'd0;
        end else if (regs_write) begin
            case (regs_addr)
                reg_ctrl0: begin
                    mode   <= regs_wrdata[7:5];
                    vscale <= regs_wrdata[4:3];
                    hscale <= regs_wrdata[2:1];
                    enable <= regs_wrdata[0];
                end
                reg_base_lo:    bitmap_base[7:0]  <= regs_wrdata;
                reg_base_hi:    bitmap_base[15:8] <= regs_wrdata;
                reg_stride:     stride            <= regs_wrdata;
                reg_hscroll_hi: palette_offset    <= regs_wrdata[3:0];
                default: begin
                    // Unmapped addresses ignore writes
                end
            endcase
        end
    end

    ////////////////////
    // Read mux
    ////////////////////
    always_comb begin
        case (regs_addr)
            reg_ctrl0:      regs_rddata = {mode, vscale, hscale, enable};
            reg_base_lo:    regs_rddata = bitmap_base[7:0];
            reg_base_hi:    regs_rddata = bitmap_base[15:8];
            reg_stride:     regs_rddata = stride;
            reg_hscroll_hi: regs_rddata = {4'h0, palette_offset};  // Upper nibble unused
            default:        regs_rddata = 8'h00;
        endcase
    end

    // The renderer sees a new mode only after a CTRL0 write
    a_mode_needs_write: assert property (@(posedge clk) disable iff (rst)
        $changed(mode) |-> $past(regs_write && regs_addr == reg_ctrl0))
        else $error("mode changed without a CTRL0 write");

endmodule

//--- verilog/line_fetcher.sv
`timescale 1ns/1ps

module line_fetcher (
    input  logic                                  clk,
    input  logic                                  rst,
    input  logic                                  start_of_screen,
    input  logic                                  start_of_line,

    // Layer controls
    input  logic [2:0]                            mode,
    input  logic [1:0]                            vscale,
    input  logic                                  enable,
    input  logic [layer_pkg::word_addr_width-1:0] bitmap_base,
    input  logic [7:0]                            stride,

    // Bus master
    output logic [layer_pkg::bus_addr_width-1:0]  bus_addr,
    output logic                                  bus_strobe,
    input  logic [layer_pkg::bus_data_width-1:0]  bus_rddata,
    input  logic                                  bus_ack,

    // Word hand-off to the serializer
    output logic                                  word_valid,
    input  logic                                  word_ready,
    output layer_pkg::fetch_word_t                word_data,
    input  logic                                  line_done
);
    import layer_pkg::*;

    logic [fetch_state_width-1:0] state;
    logic                         req;          // Bus request held until ack
    logic [word_addr_width-1:0]   line_addr;    // First word of the current line
    logic [word_addr_width-1:0]   word_addr;    // Next word to fetch
    logic [word_addr_width-1:0]   next_line_addr;
    logic [word_addr_width-1:0]   line_start_addr;
    logic [1:0]                   vscale_cnt;
    logic                         screen_top;   // Next line is the first of the screen
    logic                         bitmap_line;

    assign bitmap_line = enable && (mode >= mode_bmp2);

    // No strobe in the ack cycle
    assign bus_strobe = req && !bus_ack;

    ////////////////////
    // Vertical scaling
    ////////////////////
    assign next_line_addr = line_addr + {{(word_addr_width-8){1'b0}}, stride};

    // Repeat the line vscale+1 times before stepping by the stride
    assign line_start_addr = (!screen_top && vscale_cnt == vscale) ? next_line_addr : line_addr;

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            line_addr  <= '0;
            vscale_cnt <= 2'd0;
            screen_top <= 1'b0;
        end else if (start_of_screen) begin
            line_addr  <= bitmap_base;
            vscale_cnt <= 2'd0;
            screen_top <= 1'b1;
        end else if (start_of_line) begin
            line_addr  <= line_start_addr;
            screen_top <= 1'b0;
            if (screen_top || vscale_cnt == vscale) begin
                vscale_cnt <= 2'd0;
            end else begin
                vscale_cnt <= vscale_cnt + 2'd1;
            end
        end
    end

    ////////////////////
    // Fetch FSM
    ////////////////////
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            state      <= fetch_idle;
            req        <= 1'b0;
            word_valid <= 1'b0;
            bus_addr   <= '0;
            word_addr  <= '0;
        end else begin
            case (state)
                fetch_issue: begin
                    bus_addr  <= {word_addr, 2'b00};
                    word_addr <= word_addr + 1'b1;
                    req       <= 1'b1;
                    state     <= fetch_wait;
                end

                fetch_wait: begin
                    if (bus_ack) begin
                        req <= 1'b0;
                        if (line_done) begin
                            state <= fetch_idle;  // Line already full so the word is dropped
                        end else begin
                            word_valid <= 1'b1;
                            state      <= fetch_hold;
                        end
                    end
                end

                fetch_hold: begin
                    if (line_done) begin
                        word_valid <= 1'b0;
                        state      <= fetch_idle;
                    end else if (word_ready) begin
                        // Word taken so the next fetch goes out at once
                        word_valid <= 1'b0;
                        bus_addr   <= {word_addr, 2'b00};
                        word_addr  <= word_addr + 1'b1;
                        req        <= 1'b1;
                        state      <= fetch_wait;
                    end
                end

                default: begin
                    // Idle until a bitmap line starts
                end
            endcase

            if (start_of_screen) begin
                word_addr <= bitmap_base;
            end

            if (start_of_line) begin
                req        <= 1'b0;
                word_valid <= 1'b0;
                word_addr  <= line_start_addr;
                state      <= bitmap_line ? fetch_issue : fetch_idle;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (state == fetch_wait && bus_ack) begin
            word_data <= bus_rddata;
        end
    end

    // A pending request keeps its address until the memory answers
    a_addr_stable: assert property (@(posedge clk) disable iff (rst)
        bus_strobe && !start_of_line |=> req && $stable(bus_addr))
        else $error("bus_addr moved while waiting for ack");

endmodule

//--- verilog/pixel_serializer.sv
`timescale 1ns/1ps

module pixel_serializer (
    input  logic                                    clk,
    input  logic                                    rst,
    input  logic                                    start_of_line,

    // Layer controls
    input  logic [2:0]                              mode,
    input  logic [1:0]                              hscale,
    input  logic [3:0]                              palette_offset,

    // Word hand-off from the fetcher
    input  logic                                    word_valid,
    output logic                                    word_ready,
    input  layer_pkg::fetch_word_t                  word_data,
    output logic                                    line_done,

    // Line buffer
    output logic [layer_pkg::linebuf_idx_width-1:0] linebuf_wridx,
    output logic [7:0]                              linebuf_wrdata,
    output logic                                    linebuf_wren
);
    import layer_pkg::*;

    fetch_word_t                  render_word;
    logic                         rendering;
    logic [3:0]                   pix_cnt;      // Pixel within the word
    logic [3:0]                   last_pix;
    logic [1:0]                   hscale_cnt;   // Repeats of the current pixel
    logic [linebuf_idx_width-1:0] wr_idx;
    logic [7:0]                   raw_pixel;
    logic [7:0]                   pixel;
    logic                         accept;
    logic                         write_pixel;

    assign line_done   = (wr_idx == line_pixels);
    assign word_ready  = !rendering && !line_done;
    assign accept      = word_valid && word_ready;
    assign write_pixel = rendering && !line_done;

    ////////////////////
    // Pixel select
    ////////////////////
    always_comb begin
        case (mode)
            mode_bmp8: last_pix = 4'd3;
            mode_bmp4: last_pix = 4'd7;
            default:   last_pix = 4'd15;
        endcase
    end

    // Bytes in order with the high bits of each byte first
    always_comb begin
        case (mode)
            mode_bmp8: raw_pixel = render_word.bytes[pix_cnt[1:0]];
            mode_bmp4: raw_pixel = {4'h0, render_word.nibbles[{pix_cnt[2:1], ~pix_cnt[0]}]};
            mode_bmp2: raw_pixel = {6'h00, render_word.pairs[{pix_cnt[3:2], ~pix_cnt[1:0]}]};
            default:   raw_pixel = 8'h00;
        endcase
    end

    // Colours 1 to 15 move into the palette bank while 0 stays transparent
    assign pixel = (raw_pixel[7:4] == 4'h0 && raw_pixel[3:0] != 4'h0) ?
                   {palette_offset, raw_pixel[3:0]} : raw_pixel;

    ////////////////////
    // Line write
    ////////////////////
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            rendering     <= 1'b0;
            pix_cnt       <= 4'd0;
            hscale_cnt    <= 2'd0;
            wr_idx        <= '0;
            linebuf_wridx <= '0;
            linebuf_wren  <= 1'b0;
        end else begin
            linebuf_wren <= 1'b0;

            if (start_of_line) begin
                rendering  <= 1'b0;
                pix_cnt    <= 4'd0;
                hscale_cnt <= 2'd0;
                wr_idx     <= '0;
            end else if (accept) begin
                rendering  <= 1'b1;
                pix_cnt    <= 4'd0;
                hscale_cnt <= 2'd0;
            end else if (write_pixel) begin
                linebuf_wren  <= 1'b1;
                linebuf_wridx <= wr_idx;
                wr_idx        <= wr_idx + 1'b1;

                if (hscale_cnt == hscale) begin
                    hscale_cnt <= 2'd0;
                    if (pix_cnt == last_pix) begin
                        rendering <= 1'b0;  // Word used up
                    end else begin
                        pix_cnt <= pix_cnt + 4'd1;
                    end
                end else begin
                    hscale_cnt <= hscale_cnt + 2'd1;
                end
            end
        end
    end

    always_ff @(posedge clk) begin
        if (accept) begin
            render_word <= word_data;
        end
        if (write_pixel) begin
            linebuf_wrdata <= pixel;
        end
    end

    a_idx_in_line: assert property (@(posedge clk) disable iff (rst)
        linebuf_wren |-> linebuf_wridx < line_pixels)
        else $error("line buffer write past the end of the line");

    // A word offered during rendering stays put until taken
    a_no_accept_busy: assert property (@(posedge clk) disable iff (rst)
        rendering && word_valid && !line_done && !start_of_line |=>
            word_valid && $stable(word_data))
        else $error("word consumed while a word was rendering");

endmodule

//--- verilog/layer_renderer.sv
`timescale 1ns/1ps

module layer_renderer (
    input  logic                                    clk,
    input  logic                                    rst,
    input  logic                                    start_of_screen,
    input  logic                                    start_of_line,

    // Register bus
    input  logic [layer_pkg::reg_addr_width-1:0]    regs_addr,
    input  logic [layer_pkg::reg_data_width-1:0]    regs_wrdata,
    input  logic                                    regs_write,
    output logic [layer_pkg::reg_data_width-1:0]    regs_rddata,

    // Bus master
    output logic [layer_pkg::bus_addr_width-1:0]    bus_addr,
    output logic                                    bus_strobe,
    input  logic [layer_pkg::bus_data_width-1:0]    bus_rddata,
    input  logic                                    bus_ack,

    // Line buffer
    output logic [layer_pkg::linebuf_idx_width-1:0] linebuf_wridx,
    output logic [7:0]                              linebuf_wrdata,
    output logic                                    linebuf_wren
);
    import layer_pkg::*;

    logic [2:0]                 mode;
    logic [1:0]                 vscale;
    logic [1:0]                 hscale;
    logic                       enable;
    logic [word_addr_width-1:0] bitmap_base;
    logic [7:0]                 stride;
    logic [3:0]                 palette_offset;

    // Fetcher to serializer
    logic                       word_valid;
    logic                       word_ready;
    fetch_word_t                word_data;
    logic                       line_done;

    layer_regs u_regs (
        .clk            (clk),
        .rst            (rst),
        .regs_addr      (regs_addr),
        .regs_wrdata    (regs_wrdata),
        .regs_write     (regs_write),
        .regs_rddata    (regs_rddata),
        .mode           (mode),
        .vscale         (vscale),
        .hscale         (hscale),
        .enable         (enable),
        .bitmap_base    (bitmap_base),
        .stride         (stride),
        .palette_offset (palette_offset)
    );

    line_fetcher u_fetcher (
        .clk             (clk),
        .rst             (rst),
        .start_of_screen (start_of_screen),
        .start_of_line   (start_of_line),
        .mode            (mode),
        .vscale          (vscale),
        .enable          (enable),
        .bitmap_base     (bitmap_base),
        .stride          (stride),
        .bus_addr        (bus_addr),
        .bus_strobe      (bus_strobe),
        .bus_rddata      (bus_rddata),
        .bus_ack         (bus_ack),
        .word_valid      (word_valid),
        .word_ready      (word_ready),
        .word_data       (word_data),
        .line_done       (line_done)
    );

    pixel_serializer u_serializer (
        .clk            (clk),
        .rst            (rst),
        .start_of_line  (start_of_line),
        .mode           (mode),
        .hscale         (hscale),
        .palette_offset (palette_offset),
        .word_valid     (word_valid),
        .word_ready     (word_ready),
        .word_data      (word_data),
        .line_done      (line_done),
        .linebuf_wridx  (linebuf_wridx),
        .linebuf_wrdata (linebuf_wrdata),
        .linebuf_wren   (linebuf_wren)
    );

endmodule

//--- bench/bus_memory_model.sv
`timescale 1ns/1ps

module bus_memory_model (
    input  logic                                 clk,
    input  logic                                 rst,
    input  logic [layer_pkg::bus_addr_width-1:0] bus_addr,
    input  logic                                 bus_strobe,
    output logic [layer_pkg::bus_data_width-1:0] bus_rddata,
    output logic                                 bus_ack
);
    import layer_pkg::*;

    logic [bus_data_width-1:0]  mem [0:(1<<word_addr_width)-1];
    logic [15:0]                lfsr_state;
    logic                       busy;
    logic [1:0]                 delay_cnt;     // Extra cycles before ack
    logic [word_addr_width-1:0] req_word;
    logic                       delay_hi;
    logic                       delay_lo;

    // Galois LFSR stepped once per bit
    function logic lfsr_bit();
        logic out;
        out = lfsr_state[0];
        lfsr_state = lfsr_state >> 1;
        if (out) begin
            lfsr_state = lfsr_state ^ 16'hB400;
        end
        return out;
    endfunction

    initial begin
        lfsr_state = 16'd77;
        for (int w = 0; w < (1 << word_addr_width); w++) begin
            for (int b = 0; b < bus_data_width; b++) begin
                mem[w][b] = lfsr_bit();
            end
        end
    end

    ////////////////////
    // Bus slave
    ////////////////////
    always @(posedge clk or posedge rst) begin
        if (rst) begin
            bus_ack    <= 1'b0;
            bus_rddata <= '0;
            busy       <= 1'b0;
            delay_cnt  <= 2'd0;
            req_word   <= '0;
        end else if (bus_ack) begin
            bus_ack <= 1'b0;  // One-cycle ack
        end else if (busy) begin
            if (delay_cnt == 2'd0) begin
                bus_ack    <= 1'b1;
                bus_rddata <= mem[req_word];
                busy       <= 1'b0;
            end else begin
                delay_cnt <= delay_cnt - 2'd1;
            end
        end else if (bus_strobe) begin
            delay_hi = lfsr_bit();
            delay_lo = lfsr_bit();
            busy      <= 1'b1;
            req_word  <= bus_addr[bus_addr_width-1:2];
            delay_cnt <= {delay_hi, delay_lo};
        end
    end

endmodule

//--- bench/tb_layer_renderer.sv
`timescale 1ns/1ps

module tb_layer_renderer;
    import layer_pkg::*;

    localparam int clk_period   = 100;
    localparam int test_lines   = 7;
    localparam int line_budget  = 640 * 4 * 4;  // Worst case clocks per line
    localparam int reset_cycles = 16;

    logic                         clk;
    logic                         rst;
    logic                         start_of_screen;
    logic                         start_of_line;
    logic [reg_addr_width-1:0]    regs_addr;
    logic [reg_data_width-1:0]    regs_wrdata;
    logic                         regs_write;
    logic [reg_data_width-1:0]    regs_rddata;
    logic [bus_addr_width-1:0]    bus_addr;
    logic                         bus_strobe;
    logic [bus_data_width-1:0]    bus_rddata;
    logic                         bus_ack;
    logic [linebuf_idx_width-1:0] linebuf_wridx;
    logic [7:0]                   linebuf_wrdata;
    logic                         linebuf_wren;

    logic [7:0]                   line_cap [0:639];
    int                           write_count;
    int                           strobe_count;
    int                           error_count;
    logic                         strobe_d;
    logic [bus_addr_width-1:0]    addr_log [$];

    layer_renderer UUT (
        .clk             (clk),
        .rst             (rst),
        .start_of_screen (start_of_screen),
        .start_of_line   (start_of_line),
        .regs_addr       (regs_addr),
        .regs_wrdata     (regs_wrdata),
        .regs_write      (regs_write),
        .regs_rddata     (regs_rddata),
        .bus_addr        (bus_addr),
        .bus_strobe      (bus_strobe),
        .bus_rddata      (bus_rddata),
        .bus_ack         (bus_ack),
        .linebuf_wridx   (linebuf_wridx),
        .linebuf_wrdata  (linebuf_wrdata),
        .linebuf_wren    (linebuf_wren)
    );

    bus_memory_model mem_model (
        .clk        (clk),
        .rst        (rst),
        .bus_addr   (bus_addr),
        .bus_strobe (bus_strobe),
        .bus_rddata (bus_rddata),
        .bus_ack    (bus_ack)
    );

    always #(clk_period / 2) clk = ~clk;

    ////////////////////
    // Checking
    ////////////////////
    task automatic check_value(input string name, input logic [31:0] got,
                               input logic [31:0] exp);
        if (got !== exp) begin
            error_count++;
            $display("MISMATCH at %0d ns: %s got %h expected %h", $time, name, got, exp);
            $display("STATUS: FAIL");
            $fatal(1, "first error");
        end
    endtask

    task automatic fail_run(input string why);
        $display("ERROR at %0d ns: %s", $time, why);
        $display("STATUS: FAIL");
        $fatal(1, "run aborted");
    endtask

    // Pixel p of a line starting at word address start
    function automatic logic [7:0] expected_pixel(input logic [2:0] m, input logic [15:0] start,
                                                  input int p, input logic [3:0] pal);
        int          per_word;
        int          k;
        logic [15:0] waddr;
        logic [31:0] w;
        logic [7:0]  b;
        logic [7:0]  raw;
        per_word = (m == mode_bmp8) ? 4 : (m == mode_bmp4) ? 8 : 16;
        waddr = start + 16'(p / per_word);
        w = mem_model.mem[waddr];
        b = w[8 * ((p % per_word) / (per_word / 4)) +: 8];
        k = p % (per_word / 4);  // Position within the byte counting from the high bits
        case (m)
            mode_bmp8: raw = b;
            mode_bmp4: raw = (k == 0) ? {4'h0, b[7:4]} : {4'h0, b[3:0]};
            default:   raw = (b >> (6 - 2 * k)) & 8'h03;
        endcase
        if (raw != 8'h00 && raw < 8'h10) begin
            return {pal, raw[3:0]};
        end
        return raw;
    endfunction

    // Line buffer and bus capture
    always @(posedge clk) begin
        if (!rst && linebuf_wren) begin
            if (write_count >= line_pixels) begin
                fail_run("line buffer written after the line was complete");
            end
            check_value("linebuf_wridx", 32'(linebuf_wridx), 32'(write_count));
            line_cap[linebuf_wridx] = linebuf_wrdata;
            write_count++;
        end
        if (!rst && bus_strobe) begin
            strobe_count++;
            if (!strobe_d) begin
                addr_log.push_back(bus_addr);
            end
        end
        strobe_d = rst ? 1'b0 : bus_strobe;
    end

    ////////////////////
    // Drivers
    ////////////////////
    task automatic write_reg(input logic [3:0] addr, input logic [7:0] data);
        @(posedge clk) #1;
        regs_addr   = addr;
        regs_wrdata = data;
        regs_write  = 1'b1;
        @(posedge clk) #1;
        regs_write  = 1'b0;
    endtask

    task automatic read_expect(input logic [3:0] addr, input logic [7:0] exp);
        @(posedge clk) #1;
        regs_addr = addr;
        #10;
        check_value($sformatf("regs_rddata[%0d]", addr), 32'(regs_rddata), 32'(exp));
    endtask

    task automatic set_base(input logic [15:0] base);
        write_reg(reg_base_lo, base[7:0]);
        write_reg(reg_base_hi, base[15:8]);
    endtask

    task automatic pulse_screen();
        @(posedge clk) #1;
        start_of_screen = 1'b1;
        @(posedge clk) #1;
        start_of_screen = 1'b0;
    endtask

    task automatic pulse_line();
        write_count  = 0;
        strobe_count = 0;
        addr_log.delete();
        @(posedge clk) #1;
        start_of_line = 1'b1;
        @(posedge clk) #1;
        start_of_line = 1'b0;
    endtask

    // One rendered line compared pixel by pixel
    task automatic run_line(input logic [2:0] m, input logic [15:0] start,
                            input int hs, input logic [3:0] pal);
        int cycles;
        pulse_line();
        cycles = 0;
        while (write_count < line_pixels) begin
            @(posedge clk) #1;
            cycles++;
            if (cycles > line_budget) begin
                fail_run("line did not complete in time");
            end
        end
        repeat (12) @(posedge clk);  // Let a dropped fetch finish
        #1;
        check_value("bus_addr first", 32'(addr_log[0]), 32'({start, 2'b00}));
        for (int i = 0; i < line_pixels; i++) begin
            check_value($sformatf("line_cap[%0d]", i), 32'(line_cap[i]),
                        32'(expected_pixel(m, start, i / (hs + 1), pal)));
        end
    endtask

    ////////////////////
    // Tests
    ////////////////////
    task automatic registers_read_back();
        read_expect(reg_ctrl0, 8'h00);
        read_expect(reg_base_lo, 8'h00);
        read_expect(reg_base_hi, 8'h80);
        read_expect(reg_stride, 8'h00);
        read_expect(reg_hscroll_hi, 8'h00);
        write_reg(reg_ctrl0, 8'h5A);
        write_reg(reg_base_lo, 8'h3C);
        write_reg(reg_base_hi, 8'hC3);
        write_reg(reg_stride, 8'h96);
        write_reg(reg_hscroll_hi, 8'hA5);
        write_reg(4'h1, 8'hFF);
        read_expect(reg_ctrl0, 8'h5A);
        read_expect(reg_base_lo, 8'h3C);
        read_expect(reg_base_hi, 8'hC3);
        read_expect(reg_stride, 8'h96);
        read_expect(reg_hscroll_hi, 8'h05);  // High nibble unused
        read_expect(4'h1, 8'h00);
        read_expect(4'h8, 8'h00);
    endtask

    task automatic plain_8bpp_line();
        set_base(16'h1234);
        write_reg(reg_hscroll_hi, 8'h00);
        write_reg(reg_ctrl0, {mode_bmp8, 2'd0, 2'd0, 1'b1});
        pulse_screen();
        run_line(mode_bmp8, 16'h1234, 0, 4'h0);
    endtask

    task automatic scaled_4bpp_line();
        set_base(16'h8000);
        write_reg(reg_hscroll_hi, 8'h03);
        write_reg(reg_ctrl0, {mode_bmp4, 2'd0, 2'd1, 1'b1});
        pulse_screen();
        run_line(mode_bmp4, 16'h8000, 1, 4'h3);
    endtask

    task automatic vscaled_2bpp_lines();
        set_base(16'hFFF0);  // Third line wraps the word address
        write_reg(reg_stride, 8'h21);
        write_reg(reg_hscroll_hi, 8'h05);
        write_reg(reg_ctrl0, {mode_bmp2, 2'd1, 2'd0, 1'b1});
        pulse_screen();
        run_line(mode_bmp2, 16'hFFF0, 0, 4'h5);
        run_line(mode_bmp2, 16'hFFF0, 0, 4'h5);
        run_line(mode_bmp2, 16'h0011, 0, 4'h5);
    endtask

    task automatic quiet_line(input string label);
        pulse_screen();
        pulse_line();
        repeat (line_pixels + 16) @(posedge clk);
        #1;
        check_value({label, " bus_strobe count"}, 32'(strobe_count), 32'd0);
        check_value({label, " linebuf_wren count"}, 32'(write_count), 32'd0);
    endtask

    task automatic disabled_and_tile_lines();
        write_reg(reg_ctrl0, {mode_bmp8, 2'd0, 2'd0, 1'b0});
        quiet_line("disabled");
        write_reg(reg_ctrl0, {3'd3, 2'd0, 2'd0, 1'b1});
        quiet_line("tile mode");
    endtask

    ////////////////////
    // Main sequence
    ////////////////////
    initial begin
        clk             = 1'b0;
        rst             = 1'b1;
        start_of_screen = 1'b0;
        start_of_line   = 1'b0;
        regs_addr       = '0;
        regs_wrdata     = '0;
        regs_write      = 1'b0;
        write_count     = 0;
        strobe_count    = 0;
        error_count     = 0;
        strobe_d        = 1'b0;
        repeat (reset_cycles) @(posedge clk);
        #1 rst = 1'b0;

        registers_read_back();
        plain_8bpp_line();
        scaled_4bpp_line();
        vscaled_2bpp_lines();
        disabled_and_tile_lines();

        if (error_count == 0) begin
            $display("STATUS: PASS");
            $finish;
        end else begin
            $display("STATUS: FAIL");
            $fatal(1, "errors seen");
        end
    end

    // Watchdog sized from the number of lines rendered
    initial begin
        #((reset_cycles + test_lines * line_budget) * clk_period);
        $display("ERROR: watchdog expired before the tests finished");
        $display("STATUS: FAIL");
        $fatal(1, "timeout");
    end

endmodule

//--- sim.f
verilog/layer_pkg.sv
verilog/layer_regs.sv
verilog/line_fetcher.sv
verilog/pixel_serializer.sv
verilog/layer_renderer.sv
bench/bus_memory_model.sv
bench/tb_layer_renderer.sv

//--- run_sim.sh
#!/bin/sh
# Build with Verilator and run, pass only if the testbench reports it
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --assert -Wno-fatal --top-module tb_layer_renderer \
    -f sim.f -o vsim_tb \
    && ./obj_dir/vsim_tb | tee /dev/stderr | grep -q "STATUS: PASS" \
    && echo "Simulation passed" \
    || { echo "Simulation failed"; exit 1; }
